// ==== wb_soc_top.f ====
+incdir+include
src/wb_pkg.sv
src/wb_arbiter.sv
src/wb_decoder.sv
src/wb_ram.sv
src/wb_gpio.sv
src/wb_soc_top.sv
test/wb_soc_asserts.sv
test/wb_soc_tb.sv

// ==== Bender.yml ====
package:
  name: wb_soc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/wb_pkg.sv
      - src/wb_arbiter.sv
      - src/wb_decoder.sv
      - src/wb_ram.sv
      - src/wb_gpio.sv
      - src/wb_soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/wb_soc_asserts.sv
      - test/wb_soc_tb.sv

// ==== test/wb_soc_tb.sv ====
`timescale 1ns/100ps
`include "wb_soc_macros.svh"

module wb_soc_tb;

  localparam int timeout_cycles = 50;
  localparam bit port_cpu       = 1'b0;
  localparam bit port_dbg       = 1'b1;

  logic                 clk;
  logic                 rst;
  wb_pkg::bus_req_t     cpu_req;
  wb_pkg::bus_rsp_t     cpu_rsp;
  wb_pkg::bus_req_t     dbg_req;
  wb_pkg::bus_rsp_t     dbg_rsp;
  logic [`WB_KEY_W-1:0] keys;
  logic [`WB_LED_W-1:0] led;
  logic [31:0]          ram_model [`WB_RAM_WORDS];
  logic [31:0]          burst_q [$];                   // Read data in Ack order.

  wb_soc_top u_wb_soc_top (
    .clk       (clk),
    .rst       (rst),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .dbg_req_i (dbg_req),
    .dbg_rsp_o (dbg_rsp),
    .keys_i    (keys),
    .led_o     (led)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Byte-lane write, as the bus defines Sel.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i])
        res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic set_req(input bit port, input wb_pkg::bus_req_t req);
    if (port)
      dbg_req = req;
    else
      cpu_req = req;
  endtask

  function automatic wb_pkg::bus_rsp_t rsp_of(input bit port);
    return port ? dbg_rsp : cpu_rsp;
  endfunction

  task automatic bus_xfer(input bit port, input bit we, input logic [31:0] adr,
                          input logic [3:0] sel, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    wb_pkg::bus_req_t req;
    wb_pkg::bus_rsp_t rsp;
    int               cycles;
    req      = '0;
    req.Cyc  = 1'b1;
    req.Stb  = 1'b1;
    req.We   = we;
    req.Sel  = sel;
    req.Adr  = adr;
    req.Data = wdata;
    @(posedge clk);
    #1;
    set_req(port, req);
    cycles = 0;
    do
    begin
      @(negedge clk);                                  // Stall as seen at the next edge.
      rsp = rsp_of(port);
      cycles++;
    end
    while (rsp.Stall && cycles < timeout_cycles);
    if (rsp.Stall)
    begin
      $display("Timeout: the request to %h was never accepted", adr);
      abort_run();
    end
    @(posedge clk);
    #1;
    req.Stb = 1'b0;
    set_req(port, req);
    cycles = 0;
    do
    begin
      @(negedge clk);
      rsp = rsp_of(port);
      cycles++;
    end
    while (!rsp.Ack && cycles < timeout_cycles);
    if (!rsp.Ack)
    begin
      $display("Timeout: no Ack for the request to %h", adr);
      abort_run();
    end
    rdata = rsp.Data;
    err   = rsp.Err;
    @(posedge clk);
    #1;
    set_req(port, '0);                                 // Cyc drops after the last Ack.
  endtask

  task automatic write_word(input bit port, input logic [31:0] adr,
                            input logic [3:0] sel, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    bus_xfer(port, 1'b1, adr, sel, data, unused, err);
    check_value("write err", 32'h0, 32'(err));
  endtask

  task automatic read_word(input bit port, input logic [31:0] adr,
                           output logic [31:0] data, output logic err);
    bus_xfer(port, 1'b0, adr, 4'hF, 32'h0, data, err);
  endtask

  task automatic read_burst(input bit port, input logic [31:0] adr, input int n,
                            output int issued);
    wb_pkg::bus_req_t req;
    wb_pkg::bus_rsp_t rsp;
    int               acks;
    int               cycles;
    req     = '0;
    req.Cyc = 1'b1;
    req.Stb = 1'b1;
    req.Sel = 4'hF;
    req.Adr = adr;
    issued  = 0;
    acks    = 0;
    cycles  = 0;
    burst_q.delete();
    @(posedge clk);
    #1;
    set_req(port, req);
    while (acks < n && cycles < timeout_cycles)
    begin
      @(negedge clk);
      rsp = rsp_of(port);
      cycles++;
      if (rsp.Ack)
      begin
        burst_q.push_back(rsp.Data);
        acks++;
      end
      if (req.Stb && !rsp.Stall)
        issued++;                                      // Taken at the coming edge.
      @(posedge clk);
      #1;
      req.Stb = (issued < n);
      req.Adr = adr + 32'(4 * issued);
      set_req(port, req);
    end
    if (acks < n)
    begin
      $display("Timeout: burst at %h got %0d of %0d Acks", adr, acks, n);
      abort_run();
    end
    // Hold Cyc a little longer so a surplus Ack is caught.
    for (int extra = 0; extra < 2; extra++)
    begin
      @(negedge clk);
      rsp = rsp_of(port);
      if (rsp.Ack)
        burst_q.push_back(rsp.Data);
      @(posedge clk);
      #1;
    end
    set_req(port, '0);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_ram_rw();
    logic [31:0] adr;
    logic [31:0] data;
    logic [31:0] got;
    logic [3:0]  sel;
    logic        err;
    for (int idx = 64; idx < 72; idx++)
    begin
      adr            = `WB_RAM_BASE + 32'(idx * 4);
      data           = $urandom();
      write_word(port_cpu, adr, 4'hF, data);
      ram_model[idx] = data;
      data           = $urandom();
      sel            = 4'($urandom());
      write_word(port_cpu, adr, sel, data);
      ram_model[idx] = merge_bytes(ram_model[idx], data, sel);
    end
    for (int idx = 64; idx < 72; idx++)
    begin
      read_word(port_cpu, `WB_RAM_BASE + 32'(idx * 4), got, err);
      check_value("ram_rw data", ram_model[idx], got);
      check_value("ram_rw err", 32'h0, 32'(err));
    end
  endtask

  task automatic test_burst();
    int issued;
    for (int idx = 200; idx < 204; idx++)
    begin
      ram_model[idx] = $urandom();
      write_word(port_cpu, `WB_RAM_BASE + 32'(idx * 4), 4'hF, ram_model[idx]);
    end
    read_burst(port_cpu, `WB_RAM_BASE + 32'(200 * 4), 4, issued);
    check_value("burst strobes", 32'd4, 32'(issued));
    check_value("burst acks", 32'd4, 32'(burst_q.size()));
    for (int i = 0; i < 4; i++)
      check_value("burst data", ram_model[200 + i], burst_q[i]);
  endtask

  task automatic test_gpio();
    logic [31:0] data;
    logic [31:0] got;
    logic        err;
    data = $urandom();
    write_word(port_cpu, `WB_GPIO_BASE, 4'h1, data);
    check_value("gpio led_o", 32'(data[`WB_LED_W-1:0]), 32'(led));
    read_word(port_cpu, `WB_GPIO_BASE, got, err);
    check_value("gpio led read", 32'(data[`WB_LED_W-1:0]), got);
    @(posedge clk);
    #1;
    keys = `WB_KEY_W'($urandom());
    repeat (3) @(posedge clk);                         // Through the synchronizer.
    read_word(port_cpu, `WB_GPIO_BASE + 32'h4, got, err);
    check_value("gpio keys", 32'(keys), got);
    check_value("gpio err", 32'h0, 32'(err));
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    logic [31:0] got;
    logic        err;
    read_word(port_cpu, 32'h8000_0000, got, err);
    check_value("unmapped err", 32'h1, 32'(err));
    check_value("unmapped data", 32'h0, got);
    data           = $urandom();
    ram_model[300] = data;
    write_word(port_cpu, `WB_RAM_BASE + 32'(300 * 4), 4'hF, data);
    read_word(port_cpu, `WB_RAM_BASE + 32'(300 * 4), got, err);
    check_value("unmapped ram after", data, got);
  endtask

  // Debug port owns the bus, so the CPU port must stay held off.
  task automatic watch_waiting();
    bit seen;
    seen = 1'b0;
    for (int cycles = 0; cycles < timeout_cycles; cycles++)
    begin
      @(negedge clk);
      if (dbg_req.Cyc)
      begin
        seen = 1'b1;
        assert (cpu_rsp.Stall && !cpu_rsp.Ack)
        else
        begin
          $display("CPU port was not stalled while the debug port owned the bus");
          abort_run();
        end
      end
      else if (seen)
        return;
    end
    $display("Timeout: debug port never released the bus");
    abort_run();
  endtask

  task automatic test_arbitration();
    logic [31:0] dbg_data;
    logic [31:0] cpu_data;
    logic [31:0] got;
    logic        err;
    dbg_data = $urandom();
    cpu_data = $urandom();
    // CPU won last, so the debug port takes the tie.
    fork
      write_word(port_dbg, `WB_RAM_BASE + 32'(400 * 4), 4'hF, dbg_data);
      write_word(port_cpu, `WB_RAM_BASE + 32'(401 * 4), 4'hF, cpu_data);
      watch_waiting();
    join
    read_word(port_cpu, `WB_RAM_BASE + 32'(400 * 4), got, err);
    check_value("arb debug word", dbg_data, got);
    read_word(port_cpu, `WB_RAM_BASE + 32'(401 * 4), got, err);
    check_value("arb cpu word", cpu_data, got);
  endtask

  initial
  begin
    void'($urandom(32'h746d));
    rst     = 1'b1;
    cpu_req = '0;
    dbg_req = '0;
    keys    = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_ram_rw();
    test_burst();
    test_gpio();
    test_unmapped();
    test_arbitration();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== test/wb_soc_asserts.sv ====
`timescale 1ns/100ps

module wb_soc_asserts (
  input logic             clk,
  input logic             rst,
  input wb_pkg::bus_req_t cpu_req_i,
  input wb_pkg::bus_rsp_t cpu_rsp_i,
  input wb_pkg::bus_req_t dbg_req_i,
  input wb_pkg::bus_rsp_t dbg_rsp_i
);

  logic cpu_acc;
  logic dbg_acc;

  assign cpu_acc = cpu_req_i.Cyc & cpu_req_i.Stb & ~cpu_rsp_i.Stall;   // Accepted strobe.
  assign dbg_acc = dbg_req_i.Cyc & dbg_req_i.Stb & ~dbg_rsp_i.Stall;

  //////////////////////////////
  // Response rules
  //////////////////////////////

  err_with_ack: assert property (@(posedge clk) disable iff (rst)
    !(cpu_rsp_i.Err && !cpu_rsp_i.Ack) && !(dbg_rsp_i.Err && !dbg_rsp_i.Ack))
    else $error("Err raised without Ack.");

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    (!cpu_rsp_i.Ack || cpu_req_i.Cyc) && (!dbg_rsp_i.Ack || dbg_req_i.Cyc))
    else $error("Ack while the master's Cyc is low.");

  cpu_ack_after: assert property (@(posedge clk) disable iff (rst)
    cpu_acc |=> cpu_rsp_i.Ack)
    else $error("CPU Ack missing one cycle after acceptance.");

  cpu_ack_cause: assert property (@(posedge clk) disable iff (rst)
    cpu_rsp_i.Ack |-> $past(cpu_acc))
    else $error("CPU Ack without an accepted strobe.");

  dbg_ack_after: assert property (@(posedge clk) disable iff (rst)
    dbg_acc |=> dbg_rsp_i.Ack)
    else $error("Debug Ack missing one cycle after acceptance.");

  dbg_ack_cause: assert property (@(posedge clk) disable iff (rst)
    dbg_rsp_i.Ack |-> $past(dbg_acc))
    else $error("Debug Ack without an accepted strobe.");

  ack_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(cpu_rsp_i.Ack && dbg_rsp_i.Ack))
    else $error("Both masters acknowledged together.");

endmodule

bind wb_soc_top wb_soc_asserts u_wb_soc_asserts (
  .clk       (clk),
  .rst       (rst),
  .cpu_req_i (cpu_req_i),
  .cpu_rsp_i (cpu_rsp_o),
  .dbg_req_i (dbg_req_i),
  .dbg_rsp_i (dbg_rsp_o)
);

// ==== src/wb_soc_top.sv ====
`timescale 1ns/100ps
`include "wb_soc_macros.svh"

module wb_soc_top (
  input  logic                 clk,
  input  logic                 rst,

  input  wb_pkg::bus_req_t     cpu_req_i,
  output wb_pkg::bus_rsp_t     cpu_rsp_o,

  input  wb_pkg::bus_req_t     dbg_req_i,
  output wb_pkg::bus_rsp_t     dbg_rsp_o,

  input  logic [`WB_KEY_W-1:0] keys_i,
  output logic [`WB_LED_W-1:0] led_o
);

  wb_pkg::bus_req_t bus_req;                  // Arbiter to decoder.
  wb_pkg::bus_rsp_t bus_rsp;
  wb_pkg::bus_req_t ram_req;
  wb_pkg::bus_rsp_t ram_rsp;
  wb_pkg::bus_req_t gpio_req;
  wb_pkg::bus_rsp_t gpio_rsp;

  wb_arbiter u_wb_arbiter (
    .clk       (clk),
    .rst       (rst),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_o (cpu_rsp_o),
    .dbg_req_i (dbg_req_i),
    .dbg_rsp_o (dbg_rsp_o),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp)
  );

  wb_decoder u_wb_decoder (
    .clk        (clk),
    .rst        (rst),
    .bus_req_i  (bus_req),
    .bus_rsp_o  (bus_rsp),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  wb_ram u_wb_ram (
    .clk   (clk),
    .req_i (ram_req),
    .rsp_o (ram_rsp),
    .rst   (rst)
  );

  wb_gpio u_wb_gpio (
    .clk    (clk),
    .rst    (rst),
    .req_i  (gpio_req),
    .rsp_o  (gpio_rsp),
    .keys_i (keys_i),
    .led_o  (led_o)
  );

endmodule

// ==== src/wb_gpio.sv ====
`timescale 1ns/100ps
`include "wb_soc_macros.svh"

module wb_gpio (
  input  logic                 clk,
  input  logic                 rst,
  input  wb_pkg::bus_req_t     req_i,
  output wb_pkg::bus_rsp_t     rsp_o,
  input  logic [`WB_KEY_W-1:0] keys_i,
  output logic [`WB_LED_W-1:0] led_o
);

  logic                 stb;
  logic [`WB_LED_W-1:0] led_q;
  logic [`WB_KEY_W-1:0] key_meta_q;
  logic [`WB_KEY_W-1:0] key_sync_q;
  logic [31:0]          rd_data_q;
  logic                 ack_q;

  assign stb   = req_i.Cyc & req_i.Stb;
  assign led_o = led_q;

  // Two-flop synchronizer for the asynchronous keys.
  always_ff @(posedge clk)
  begin
    key_meta_q <= keys_i;
    key_sync_q <= key_meta_q;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led_q <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= stb;
      if (stb && req_i.We && req_i.Sel[0] && req_i.Adr == 32'h0)
        led_q <= req_i.Data[`WB_LED_W-1:0];   // Byte lane 0.
    end
  end

  always_ff @(posedge clk)
  begin
    if (stb && !req_i.We)
    begin
      case (req_i.Adr)
        32'h0:   rd_data_q <= 32'(led_q);
        32'h4:   rd_data_q <= 32'(key_sync_q);
        default: rd_data_q <= '0;             // Unused offsets read zero.
      endcase
    end
  end

  always_comb
  begin
    rsp_o       = '0;
    rsp_o.Ack   = ack_q;
    rsp_o.Data  = rd_data_q;
  end

endmodule

// ==== src/wb_ram.sv ====
`timescale 1ns/100ps
`include "wb_soc_macros.svh"

module wb_ram (
  input  logic             clk,
  input  wb_pkg::bus_req_t req_i,
  output wb_pkg::bus_rsp_t rsp_o,
  input  logic             rst
);

  localparam int aw = $clog2(`WB_RAM_WORDS);

  logic [31:0]   mem [`WB_RAM_WORDS];
  logic [aw-1:0] idx;
  logic          stb;
  logic [31:0]   rd_data_q;
  logic          ack_q;

  assign idx = req_i.Adr[aw+1:2];             // Word address.
  assign stb = req_i.Cyc & req_i.Stb;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (stb && req_i.We)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (req_i.Sel[i])
          mem[idx][8*i +: 8] <= req_i.Data[8*i +: 8];
      end
    end
    if (stb && !req_i.We)
      rd_data_q <= mem[idx];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack_q <= 1'b0;
    else
      ack_q <= stb;                           // One cycle after acceptance.
  end

  always_comb
  begin
    rsp_o       = '0;
    rsp_o.Ack   = ack_q;
    rsp_o.Stall = 1'b0;                       // Never stalls.
    rsp_o.Data  = rd_data_q;
  end

endmodule

// ==== src/wb_decoder.sv ====
`timescale 1ns/100ps
`include "wb_soc_macros.svh"

module wb_decoder (
  input  logic             clk,
  input  logic             rst,

  input  wb_pkg::bus_req_t bus_req_i,
  output wb_pkg::bus_rsp_t bus_rsp_o,

  output wb_pkg::bus_req_t ram_req_o,
  input  wb_pkg::bus_rsp_t ram_rsp_i,

  output wb_pkg::bus_req_t gpio_req_o,
  input  wb_pkg::bus_rsp_t gpio_rsp_i
);

  localparam int cnt_w = `WB_CNT_W;

  wb_pkg::slave_sel_e sel;
  logic [cnt_w-1:0]   ram_cnt_q;
  logic [cnt_w-1:0]   gpio_cnt_q;
  logic               switch_stall;
  logic               bus_stall;
  logic               bus_acc;              // Strobe accepted this cycle.
  logic               null_ack_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb
  begin
    if (bus_req_i.Adr >= `WB_RAM_BASE && bus_req_i.Adr <= `WB_RAM_LAST)
      sel = wb_pkg::SEL_RAM;
    else if (bus_req_i.Adr >= `WB_GPIO_BASE && bus_req_i.Adr <= `WB_GPIO_LAST)
      sel = wb_pkg::SEL_GPIO;
    else
      sel = wb_pkg::SEL_NONE;
  end

  // Hold off a new slave until the old one has answered everything.
  always_comb
  begin
    switch_stall = ((ram_cnt_q != '0) && (sel != wb_pkg::SEL_RAM)) ||
                   ((gpio_cnt_q != '0) && (sel != wb_pkg::SEL_GPIO));
    bus_stall    = switch_stall;
    if (ram_cnt_q != '0)
      bus_stall = bus_stall | ram_rsp_i.Stall;
    if (gpio_cnt_q != '0)
      bus_stall = bus_stall | gpio_rsp_i.Stall;
    bus_acc = bus_req_i.Cyc & bus_req_i.Stb & ~bus_stall;
  end

  //////////////////////////////
  // Requests to slaves
  //////////////////////////////

  always_comb
  begin
    ram_req_o      = bus_req_i;
    ram_req_o.Stb  = bus_acc && (sel == wb_pkg::SEL_RAM);
    ram_req_o.Adr  = bus_req_i.Adr - `WB_RAM_BASE;        // Window offset.

    gpio_req_o     = bus_req_i;
    gpio_req_o.Stb = bus_acc && (sel == wb_pkg::SEL_GPIO);
    gpio_req_o.Adr = bus_req_i.Adr - `WB_GPIO_BASE;
  end

  //////////////////////////////
  // Outstanding counters
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ram_cnt_q  <= '0;
      gpio_cnt_q <= '0;
      null_ack_q <= 1'b0;
    end
    else
    begin
      ram_cnt_q  <= ram_cnt_q + cnt_w'(ram_req_o.Stb) - cnt_w'(ram_rsp_i.Ack);
      gpio_cnt_q <= gpio_cnt_q + cnt_w'(gpio_req_o.Stb) - cnt_w'(gpio_rsp_i.Ack);
      null_ack_q <= bus_acc && (sel == wb_pkg::SEL_NONE); // Unmapped, answer next cycle.
    end
  end

  //////////////////////////////
  // Response merge
  //////////////////////////////

  always_comb
  begin
    bus_rsp_o       = '0;
    bus_rsp_o.Stall = bus_stall;
    if (ram_rsp_i.Ack)
    begin
      bus_rsp_o.Ack  = 1'b1;
      bus_rsp_o.Err  = ram_rsp_i.Err;
      bus_rsp_o.Data = ram_rsp_i.Data;
    end
    if (gpio_rsp_i.Ack)
    begin
      bus_rsp_o.Ack  = 1'b1;
      bus_rsp_o.Err  = gpio_rsp_i.Err;
      bus_rsp_o.Data = gpio_rsp_i.Data;
    end
    if (null_ack_q)
    begin
      bus_rsp_o.Ack  = 1'b1;
      bus_rsp_o.Err  = 1'b1;
      bus_rsp_o.Data = '0;
    end
  end

endmodule

// ==== src/wb_arbiter.sv ====
`timescale 1ns/100ps

module wb_arbiter (
  input  logic             clk,
  input  logic             rst,

  input  wb_pkg::bus_req_t cpu_req_i,
  output wb_pkg::bus_rsp_t cpu_rsp_o,

  input  wb_pkg::bus_req_t dbg_req_i,
  output wb_pkg::bus_rsp_t dbg_rsp_o,

  output wb_pkg::bus_req_t bus_req_o,
  input  wb_pkg::bus_rsp_t bus_rsp_i
);

  // What a master without the bus sees.
  localparam wb_pkg::bus_rsp_t rsp_blocked = '{
    Ack:   1'b0,
    Err:   1'b0,
    Stall: 1'b1,
    Data:  32'h0
  };

  wb_pkg::arb_state_e state_q;
  wb_pkg::arb_state_e state_d;
  logic               last_dbg_q;           // Debug port won the last grant.

  //////////////////////////////
  // Grant FSM
  //////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      wb_pkg::ARB_IDLE:
      begin
        if (cpu_req_i.Cyc && dbg_req_i.Cyc)
          state_d = last_dbg_q ? wb_pkg::ARB_CPU : wb_pkg::ARB_DBG;
        else if (cpu_req_i.Cyc)
          state_d = wb_pkg::ARB_CPU;
        else if (dbg_req_i.Cyc)
          state_d = wb_pkg::ARB_DBG;
      end
      wb_pkg::ARB_CPU:
      begin
        if (!cpu_req_i.Cyc)
          state_d = wb_pkg::ARB_IDLE;       // Lock ends with Cyc.
      end
      wb_pkg::ARB_DBG:
      begin
        if (!dbg_req_i.Cyc)
          state_d = wb_pkg::ARB_IDLE;
      end
      default:
        state_d = wb_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= wb_pkg::ARB_IDLE;
      last_dbg_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == wb_pkg::ARB_IDLE && state_d != wb_pkg::ARB_IDLE)
        last_dbg_q <= (state_d == wb_pkg::ARB_DBG);
    end
  end

  //////////////////////////////
  // Bus mux
  //////////////////////////////

  always_comb
  begin
    bus_req_o = '0;                         // No cycle while idle.
    cpu_rsp_o = rsp_blocked;
    dbg_rsp_o = rsp_blocked;
    case (state_q)
      wb_pkg::ARB_CPU:
      begin
        bus_req_o = cpu_req_i;
        cpu_rsp_o = bus_rsp_i;
      end
      wb_pkg::ARB_DBG:
      begin
        bus_req_o = dbg_req_i;
        dbg_rsp_o = bus_rsp_i;
      end
      default:
      begin
        bus_req_o = '0;
      end
    endcase
  end

endmodule

// ==== src/wb_pkg.sv ====
package wb_pkg;

  //////////////////////////////
  // Bus payloads
  //////////////////////////////

  // Master to slave.
  typedef struct packed {
    logic        Cyc;
    logic        Stb;
    logic        We;
    logic [3:0]  Sel;
    logic [31:0] Adr;             // Byte address.
    logic [31:0] Data;
  } bus_req_t;

  // Slave to master.
  typedef struct packed {
    logic        Ack;
    logic        Err;
    logic        Stall;
    logic [31:0] Data;
  } bus_rsp_t;

  //////////////////////////////
  // States and decode results
  //////////////////////////////

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CPU,
    ARB_DBG
  } arb_state_e;

  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_GPIO,
    SEL_NONE
  } slave_sel_e;

endpackage

// ==== include/wb_soc_macros.svh ====
`ifndef WB_SOC_MACROS_SVH
`define WB_SOC_MACROS_SVH

//////////////////////////////
// Memory map
//////////////////////////////

// On-chip RAM window, 4 KiB.
`define WB_RAM_BASE  32'h0000_0000
`define WB_RAM_LAST  32'h0000_0FFF

// GPIO window. LED register at offset 0, keys at offset 4.
`define WB_GPIO_BASE 32'hC000_0000
`define WB_GPIO_LAST 32'hC000_FFFF

//////////////////////////////
// Sizes
//////////////////////////////

`define WB_RAM_WORDS 1024          // 32-bit words.

`define WB_CNT_W     4             // Outstanding strobe counters.

`define WB_LED_W     8
`define WB_KEY_W     4

`endif
